// File: source/uart_pkg.sv
/* UART bit timing and byte type */

`default_nettype none

package uart_pkg;

   ////////////////////
   // Bit timing

   // Clocks per serial bit, kept short for simulation
   localparam int CLKS_PER_BIT = 8;
   localparam int HALF_BIT     = CLKS_PER_BIT / 2;

   // Start bit, 8 data bits, stop bit
   localparam int FRAME_BITS   = 10;
   localparam int DATA_BITS    = 8;

   ////////////////////
   // Types

   typedef logic [DATA_BITS-1:0]              uart_byte_t;
   typedef logic [$clog2(CLKS_PER_BIT)-1:0]   clk_div_t;
   typedef logic [$clog2(FRAME_BITS)-1:0]     bit_cnt_t;

   // Divider end values
   localparam clk_div_t LAST_DIV      = clk_div_t'(CLKS_PER_BIT - 1);
   localparam clk_div_t MID_DIV       = clk_div_t'(HALF_BIT - 1);

   // Bit counter end values
   localparam bit_cnt_t LAST_TX_BIT   = bit_cnt_t'(FRAME_BITS - 1);
   localparam bit_cnt_t LAST_DATA_BIT = bit_cnt_t'(DATA_BITS - 1);

endpackage

`default_nettype wire

// File: source/mem_pkg.sv
/* Memory bridge widths and types */

`default_nettype none

package mem_pkg;

   ////////////////////
   // Widths

   localparam int ADDR_WIDTH   = 12;
   localparam int DATA_WIDTH   = 16;
   localparam int NIBBLE_WIDTH = 4;
   localparam int ADDR_NIBBLES = ADDR_WIDTH / NIBBLE_WIDTH;
   localparam int DATA_NIBBLES = DATA_WIDTH / NIBBLE_WIDTH;

   typedef logic [ADDR_WIDTH-1:0]   addr_t;
   typedef logic [DATA_WIDTH-1:0]   data_t;
   typedef logic [NIBBLE_WIDTH-1:0] nibble_t;

   // Nibble position in a frame, address nibbles first
   typedef logic [2:0]              nib_idx_t;

   localparam nib_idx_t LAST_ADDR_IDX  = nib_idx_t'(ADDR_NIBBLES - 1);
   localparam nib_idx_t FIRST_DATA_IDX = nib_idx_t'(ADDR_NIBBLES);
   localparam nib_idx_t LAST_DATA_IDX  = nib_idx_t'(ADDR_NIBBLES + DATA_NIBBLES - 1);
   localparam nib_idx_t LAST_REPLY_IDX = nib_idx_t'(DATA_NIBBLES - 1);

   ////////////////////
   // Command tags, low nibble of every serial byte

   typedef enum logic [3:0] {
      TRANS      = 4'b0000,
      DATA_START = 4'b0001,
      ADDR_START = 4'b0010,
      END_WRITE  = 4'b0100,
      END_READ   = 4'b1000
   } cmd_tag_e;

   ////////////////////
   // Controller states

   typedef enum logic [2:0] {
      IDLE,
      WR_SEND,
      WR_WAIT,
      RD_SEND,
      RD_WAIT,
      RD_REPLY
   } bridge_state_e;

   // Data sits above address so the frame index selects nibbles in wire order
   typedef struct packed {
      data_t data;
      addr_t addr;
   } mem_req_t;

endpackage

`default_nettype wire

// File: source/uart_tx.sv
/* UART transmitter */

`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
   input  wire             i_clk,
   input  wire             i_nrst,

   input  wire uart_byte_t i_data,
   input  wire             i_valid,
   output logic            o_accept,
   output logic            o_busy,

   output logic            o_tx
);

   // Shift register holds the whole frame, LSB on the line
   logic [FRAME_BITS-1:0] shift_q;
   clk_div_t              div_q;
   bit_cnt_t              bit_q;

   // New byte is taken only while idle
   assign o_accept = i_valid && !o_busy;
   assign o_tx     = shift_q[0];

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_busy  <= 1'b0;
         shift_q <= '1;
         div_q   <= '0;
         bit_q   <= '0;
      end else if (o_accept) begin
         o_busy  <= 1'b1;
         // Stop bit, data LSB first, start bit
         shift_q <= {1'b1, i_data, 1'b0};
         div_q   <= '0;
         bit_q   <= '0;
      end else if (o_busy) begin
         if (div_q == LAST_DIV) begin
            div_q   <= '0;
            // Fill with ones so the line idles high
            shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
            if (bit_q == LAST_TX_BIT) begin
               o_busy <= 1'b0;
            end else begin
               bit_q <= bit_q + 1'b1;
            end
         end else begin
            div_q <= div_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/uart_rx.sv
/* UART receiver */

`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
   input  wire         i_clk,
   input  wire         i_nrst,

   input  wire         i_rx,

   output uart_byte_t  o_data,
   output logic        o_valid
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   rx_state_e  state_q;
   logic [1:0] sync_q;
   logic       rx_s;
   clk_div_t   div_q;
   bit_cnt_t   bit_q;

   ////////////////////
   // Input synchronizer

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         sync_q <= 2'b11;
      end else begin
         sync_q <= {sync_q[0], i_rx};
      end
   end

   assign rx_s = sync_q[1];

   ////////////////////
   // Frame sampling

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q <= RX_IDLE;
         div_q   <= '0;
         bit_q   <= '0;
         o_valid <= 1'b0;
      end else begin
         o_valid <= 1'b0;
         case (state_q)
            RX_IDLE: begin
               div_q <= '0;
               if (!rx_s) begin
                  state_q <= RX_START;
               end
            end
            // Recheck the start bit at its middle, a glitch goes back to idle
            RX_START: begin
               if (div_q == MID_DIV) begin
                  div_q   <= '0;
                  bit_q   <= '0;
                  state_q <= rx_s ? RX_IDLE : RX_DATA;
               end else begin
                  div_q <= div_q + 1'b1;
               end
            end
            RX_DATA: begin
               if (div_q == LAST_DIV) begin
                  div_q <= '0;
                  if (bit_q == LAST_DATA_BIT) begin
                     state_q <= RX_STOP;
                  end else begin
                     bit_q <= bit_q + 1'b1;
                  end
               end else begin
                  div_q <= div_q + 1'b1;
               end
            end
            RX_STOP: begin
               if (div_q == LAST_DIV) begin
                  // Frame with a low stop bit is dropped
                  o_valid <= rx_s;
                  state_q <= RX_IDLE;
               end else begin
                  div_q <= div_q + 1'b1;
               end
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

   // Data bits shift in LSB first at mid bit
   always_ff @(posedge i_clk) begin
      if (state_q == RX_DATA && div_q == LAST_DIV) begin
         o_data <= {rx_s, o_data[DATA_BITS-1:1]};
      end
   end

endmodule

`default_nettype wire

// File: source/nibble_packer.sv
/* Tagged nibble packer */

`timescale 1ns/1ps
`default_nettype none

module nibble_packer import uart_pkg::*, mem_pkg::*; (
   input  wire mem_req_t  i_req,
   input  wire nib_idx_t  i_nib_idx,
   input  wire            i_is_write,
   output uart_byte_t     o_byte
);

   nibble_t  nibble;
   cmd_tag_e tag;

   // Request struct is {data, addr}, so the index walks address then data
   assign nibble = i_req[i_nib_idx * NIBBLE_WIDTH +: NIBBLE_WIDTH];

   ////////////////////
   // Tag by position

   always_comb begin
      tag = TRANS;
      if (i_nib_idx == '0) begin
         tag = ADDR_START;
      end else if (i_is_write) begin
         if (i_nib_idx == LAST_ADDR_IDX || i_nib_idx == LAST_DATA_IDX) begin
            tag = END_WRITE;
         end else if (i_nib_idx == FIRST_DATA_IDX) begin
            tag = DATA_START;
         end
      end else if (i_nib_idx == LAST_ADDR_IDX) begin
         // Read frame ends after the address
         tag = END_READ;
      end
   end

   // Nibble in the high half, tag in the low half
   assign o_byte = {nibble, tag};

endmodule

`default_nettype wire

// File: source/read_assembler.sv
/* Read reply assembler */

`timescale 1ns/1ps
`default_nettype none

module read_assembler import uart_pkg::*, mem_pkg::*; (
   input  wire             i_clk,
   input  wire             i_nrst,

   input  wire uart_byte_t i_byte,
   input  wire             i_valid,

   output data_t           o_word,
   output logic            o_done
);

   nibble_t  nibble;
   cmd_tag_e tag;
   nib_idx_t idx_q;
   logic     in_range;

   assign nibble   = i_byte[7:4];
   assign tag      = cmd_tag_e'(i_byte[3:0]);
   assign in_range = (idx_q <= LAST_REPLY_IDX);

   ////////////////////
   // Reply position

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         idx_q  <= '0;
         o_done <= 1'b0;
      end else begin
         o_done <= 1'b0;
         if (i_valid) begin
            case (tag)
               DATA_START: idx_q <= nib_idx_t'(1);
               TRANS: begin
                  // Saturate past the last nibble
                  if (in_range) begin
                     idx_q <= idx_q + 1'b1;
                  end
               end
               END_READ: begin
                  idx_q  <= '0;
                  o_done <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   // Word register, held until the next reply
   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         if (tag == DATA_START) begin
            o_word <= data_t'(nibble);
         end else if ((tag == TRANS || tag == END_READ) && in_range) begin
            o_word[idx_q * NIBBLE_WIDTH +: NIBBLE_WIDTH] <= nibble;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/mem_bridge_ctrl.sv
/* Memory bridge controller */

`timescale 1ns/1ps
`default_nettype none

module mem_bridge_ctrl import mem_pkg::*; (
   input  wire       i_clk,
   input  wire       i_nrst,

   // Request levels from the user
   input  wire       i_write_valid,
   input  wire       i_read_valid,

   // Transmitter handshake
   input  wire       i_tx_accept,
   input  wire       i_tx_busy,

   // End of host reply
   input  wire       i_reply_done,

   output logic      o_tx_valid,
   output nib_idx_t  o_nib_idx,
   output logic      o_is_write,
   output logic      o_write_accept,
   output logic      o_read_accept
);

   bridge_state_e state_q;

   assign o_tx_valid = (state_q == WR_SEND) || (state_q == RD_SEND);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q        <= IDLE;
         o_nib_idx      <= '0;
         o_is_write     <= 1'b0;
         o_write_accept <= 1'b0;
         o_read_accept  <= 1'b0;
      end else begin
         o_write_accept <= 1'b0;
         o_read_accept  <= 1'b0;
         case (state_q)
            // Skip the accept cycle, valid is still up there
            IDLE: begin
               o_nib_idx <= '0;
               if (!o_write_accept && !o_read_accept) begin
                  if (i_write_valid) begin
                     o_is_write <= 1'b1;
                     state_q    <= WR_SEND;
                  end else if (i_read_valid) begin
                     o_is_write <= 1'b0;
                     state_q    <= RD_SEND;
                  end
               end
            end

            ////////////////////
            // Write frame

            WR_SEND: begin
               if (i_tx_accept) begin
                  state_q <= WR_WAIT;
               end
            end
            WR_WAIT: begin
               if (!i_tx_busy) begin
                  if (o_nib_idx == LAST_DATA_IDX) begin
                     o_write_accept <= 1'b1;
                     state_q        <= IDLE;
                  end else begin
                     o_nib_idx <= o_nib_idx + 1'b1;
                     state_q   <= WR_SEND;
                  end
               end
            end

            ////////////////////
            // Read frame and reply

            RD_SEND: begin
               if (i_tx_accept) begin
                  state_q <= RD_WAIT;
               end
            end
            RD_WAIT: begin
               if (!i_tx_busy) begin
                  if (o_nib_idx == LAST_ADDR_IDX) begin
                     state_q <= RD_REPLY;
                  end else begin
                     o_nib_idx <= o_nib_idx + 1'b1;
                     state_q   <= RD_SEND;
                  end
               end
            end
            RD_REPLY: begin
               if (i_reply_done) begin
                  o_read_accept <= 1'b1;
                  state_q       <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/mem_uart.sv
/* Memory emulator over UART */

`timescale 1ns/1ps
`default_nettype none

module mem_uart import uart_pkg::*, mem_pkg::*; (
   input  wire        i_clk,
   input  wire        i_nrst,

   // Parallel memory side
   input  wire addr_t i_addr,
   input  wire data_t i_data,
   input  wire        i_write_valid,
   input  wire        i_read_valid,
   output data_t      o_data,
   output logic       o_write_accept,
   output logic       o_read_accept,

   // Serial host side
   input  wire        i_uart_rx,
   output logic       o_uart_tx
);

   mem_req_t   req;
   nib_idx_t   nib_idx;
   logic       is_write;
   uart_byte_t tx_byte;
   logic       tx_valid;
   logic       tx_accept;
   logic       tx_busy;
   uart_byte_t rx_byte;
   logic       rx_valid;
   logic       reply_done;

   assign req = '{data: i_data, addr: i_addr};

   mem_bridge_ctrl ctrl0 (
      .i_clk          (i_clk),
      .i_nrst         (i_nrst),
      .i_write_valid  (i_write_valid),
      .i_read_valid   (i_read_valid),
      .i_tx_accept    (tx_accept),
      .i_tx_busy      (tx_busy),
      .i_reply_done   (reply_done),
      .o_tx_valid     (tx_valid),
      .o_nib_idx      (nib_idx),
      .o_is_write     (is_write),
      .o_write_accept (o_write_accept),
      .o_read_accept  (o_read_accept)
   );

   nibble_packer packer0 (
      .i_req      (req),
      .i_nib_idx  (nib_idx),
      .i_is_write (is_write),
      .o_byte     (tx_byte)
   );

   uart_tx tx0 (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_data   (tx_byte),
      .i_valid  (tx_valid),
      .o_accept (tx_accept),
      .o_busy   (tx_busy),
      .o_tx     (o_uart_tx)
   );

   uart_rx rx0 (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_rx    (i_uart_rx),
      .o_data  (rx_byte),
      .o_valid (rx_valid)
   );

   // Assembled reply is the read data
   read_assembler asm0 (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_byte  (rx_byte),
      .i_valid (rx_valid),
      .o_word  (o_data),
      .o_done  (reply_done)
   );

endmodule

`default_nettype wire

// File: sim/mem_uart_properties.sv
/* Bridge protocol properties */

`timescale 1ns/1ps
`default_nettype none

module mem_uart_properties (
   input wire i_clk,
   input wire i_nrst,
   input wire i_write_valid,
   input wire i_read_valid,
   input wire i_write_accept,
   input wire i_read_accept,
   input wire i_uart_tx
);

   int   fail_count = 0;
   logic req_seen_q;

   // Set by the first request level after reset
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         req_seen_q <= 1'b0;
      end else if (i_write_valid || i_read_valid) begin
         req_seen_q <= 1'b1;
      end
   end

   ////////////////////
   // Reset and accepts

   idle_until_request: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !req_seen_q |-> i_uart_tx && !i_write_accept && !i_read_accept)
      else begin fail_count++; $error("Bridge outputs not idle before the first request"); end

   write_accept_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_write_accept |=> !i_write_accept)
      else begin fail_count++; $error("Write accept held longer than one cycle"); end

   read_accept_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_read_accept |=> !i_read_accept)
      else begin fail_count++; $error("Read accept held longer than one cycle"); end

   write_accept_needs_valid: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $rose(i_write_accept) |-> $past(i_write_valid))
      else begin fail_count++; $error("Write accept without a write request"); end

   read_accept_needs_valid: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $rose(i_read_accept) |-> $past(i_read_valid))
      else begin fail_count++; $error("Read accept without a read request"); end

   accepts_exclusive: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !(i_write_accept && i_read_accept))
      else begin fail_count++; $error("Write and read accept high together"); end

endmodule

bind mem_uart mem_uart_properties props0 (
   .i_clk          (i_clk),
   .i_nrst         (i_nrst),
   .i_write_valid  (i_write_valid),
   .i_read_valid   (i_read_valid),
   .i_write_accept (o_write_accept),
   .i_read_accept  (o_read_accept),
   .i_uart_tx      (o_uart_tx)
);

`default_nettype wire

// File: sim/tb_mem_uart.sv
/* Memory bridge testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_mem_uart import uart_pkg::*, mem_pkg::*;;

   localparam int NUM_OPS        = 24;
   localparam int BOTH_OP        = 12;
   localparam int TIMEOUT_CYCLES = 40000;
   localparam int FRAME_NIBBLES  = ADDR_NIBBLES + DATA_NIBBLES;

   logic  i_clk;
   logic  i_nrst;
   addr_t i_addr;
   data_t i_data;
   logic  i_write_valid;
   logic  i_read_valid;
   data_t o_data;
   logic  o_write_accept;
   logic  o_read_accept;
   logic  i_uart_rx;
   logic  o_uart_tx;

   // Direction of the request on the wire for the host model
   logic  cur_is_write;
   data_t host_mem   [0:4095];
   data_t shadow_mem [0:4095];
   int    cycle_count = 0;

   mem_uart dut0 (
      .i_clk          (i_clk),
      .i_nrst         (i_nrst),
      .i_addr         (i_addr),
      .i_data         (i_data),
      .i_write_valid  (i_write_valid),
      .i_read_valid   (i_read_valid),
      .o_data         (o_data),
      .o_write_accept (o_write_accept),
      .o_read_accept  (o_read_accept),
      .i_uart_rx      (i_uart_rx),
      .o_uart_tx      (o_uart_tx)
   );

   always #20 i_clk = ~i_clk;

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1, "Stopping at the first error");
   endtask

   // Run limit and protocol property watch
   always @(posedge i_clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         abort_run($sformatf("Timeout after %0d cycles, the tests did not finish",
                             cycle_count));
      end else if (dut0.props0.fail_count != 0) begin
         abort_run("A protocol assertion on the DUT failed");
      end
   end

   ////////////////////
   // Wire format rules

   function automatic cmd_tag_e expected_tag(input logic is_write, input int pos);
      if (pos == 0) begin
         return ADDR_START;
      end else if (!is_write) begin
         return (pos == ADDR_NIBBLES - 1) ? END_READ : TRANS;
      end else if (pos == ADDR_NIBBLES - 1 || pos == FRAME_NIBBLES - 1) begin
         return END_WRITE;
      end else if (pos == ADDR_NIBBLES) begin
         return DATA_START;
      end
      return TRANS;
   endfunction

   function automatic nibble_t expected_nibble(input addr_t a, input data_t d, input int pos);
      if (pos < ADDR_NIBBLES) begin
         return a[pos*4 +: 4];
      end
      return d[(pos-ADDR_NIBBLES)*4 +: 4];
   endfunction

   ////////////////////
   // Host serial model

   // Line sampled on the falling edge in the middle of the clock
   task automatic receive_byte(output uart_byte_t b);
      uart_byte_t val;
      int         i;
      do @(negedge i_clk); while (o_uart_tx !== 1'b0);
      repeat (HALF_BIT) @(negedge i_clk);
      for (i = 0; i < DATA_BITS; i++) begin
         repeat (CLKS_PER_BIT) @(negedge i_clk);
         val[i] = o_uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge i_clk);
      assert (o_uart_tx === 1'b1)
         else abort_run("Stop bit from the DUT transmitter was low");
      b = val;
   endtask

   task automatic send_byte(input uart_byte_t b);
      logic [FRAME_BITS-1:0] frame;
      int                    i;
      frame = {1'b1, b, 1'b0};
      for (i = 0; i < FRAME_BITS; i++) begin
         i_uart_rx = frame[i];
         repeat (CLKS_PER_BIT) @(posedge i_clk);
         #2;
      end
   endtask

   task automatic send_reply(input data_t w);
      int       k;
      cmd_tag_e tag;
      for (k = 0; k < DATA_NIBBLES; k++) begin
         tag = (k == 0) ? DATA_START : (k == DATA_NIBBLES - 1) ? END_READ : TRANS;
         send_byte({w[k*4 +: 4], tag});
      end
   endtask

   initial begin : host_model
      uart_byte_t rx_b;
      addr_t      f_addr;
      data_t      f_data;
      int         pos;
      int         k;
      for (k = 0; k < 4096; k++) begin
         host_mem[k] = '0;
      end
      pos    = 0;
      f_addr = '0;
      f_data = '0;
      wait (i_nrst === 1'b1);
      forever begin
         receive_byte(rx_b);
         assert (rx_b[3:0] == expected_tag(cur_is_write, pos))
            else abort_run($sformatf("Mismatch at %0d ns: byte %0d tag %b, expected %b",
                           $time, pos, rx_b[3:0], expected_tag(cur_is_write, pos)));
         assert (rx_b[7:4] == expected_nibble(i_addr, i_data, pos))
            else abort_run($sformatf("Mismatch at %0d ns: byte %0d nibble %h, expected %h",
                           $time, pos, rx_b[7:4], expected_nibble(i_addr, i_data, pos)));
         if (pos < ADDR_NIBBLES) begin
            f_addr[pos*4 +: 4] = rx_b[7:4];
         end else begin
            f_data[(pos-ADDR_NIBBLES)*4 +: 4] = rx_b[7:4];
         end
         if (rx_b[3:0] == END_READ) begin
            @(posedge i_clk);
            #2;
            send_reply(host_mem[f_addr]);
            pos = 0;
         end else if (pos == FRAME_NIBBLES - 1) begin
            host_mem[f_addr] = f_data;
            pos = 0;
         end else begin
            pos++;
         end
      end
   end

   ////////////////////
   // Request driver

   // Returns 1 ns after the edge that shows the accept
   task automatic wait_for_accept(input logic want_write);
      do begin
         @(posedge i_clk);
         #1;
         assert (want_write ? !o_read_accept : !o_write_accept)
            else abort_run($sformatf("Mismatch at %0d ns: accept for the wrong request",
                                     $time));
      end while (want_write ? !o_write_accept : !o_read_accept);
   endtask

   task automatic do_write(input addr_t a, input data_t d, input logic also_read);
      @(posedge i_clk);
      #2;
      cur_is_write  = 1'b1;
      i_addr        = a;
      i_data        = d;
      i_write_valid = 1'b1;
      i_read_valid  = also_read;
      wait_for_accept(1'b1);
      #1;
      i_write_valid = 1'b0;
      cur_is_write  = 1'b0;
      shadow_mem[a] = d;
      assert (host_mem[a] == d)
         else abort_run($sformatf("Mismatch at %0d ns: host holds %h at %h, expected %h",
                                  $time, host_mem[a], a, d));
   endtask

   task automatic do_read(input addr_t a, input logic already_valid);
      if (!already_valid) begin
         @(posedge i_clk);
         #2;
         cur_is_write = 1'b0;
         i_addr       = a;
         i_read_valid = 1'b1;
      end
      wait_for_accept(1'b0);
      assert (o_data == host_mem[a] && o_data == shadow_mem[a])
         else abort_run($sformatf("Mismatch at %0d ns: read %h got %h, expected %h",
                                  $time, a, o_data, shadow_mem[a]));
      #1;
      i_read_valid = 1'b0;
   endtask

   initial begin : stimulus
      int    n;
      addr_t a;
      data_t d;
      i_clk         = 1'b0;
      i_nrst        = 1'b0;
      i_addr        = '0;
      i_data        = '0;
      i_write_valid = 1'b0;
      i_read_valid  = 1'b0;
      i_uart_rx     = 1'b1;
      cur_is_write  = 1'b0;
      for (n = 0; n < 4096; n++) begin
         shadow_mem[n] = '0;
      end
      void'($urandom(49));
      repeat (4) @(posedge i_clk);
      #2;
      i_nrst = 1'b1;

      // Addresses spread over 16 slots so reads often hit earlier writes
      for (n = 0; n < NUM_OPS; n++) begin
         a = addr_t'($urandom_range(15, 0) * 12'h111);
         d = data_t'($urandom);
         if (n == BOTH_OP) begin
            do_write(a, d, 1'b1);
            do_read(a, 1'b1);
         end else if ($urandom_range(1, 0) == 1) begin
            do_write(a, d, 1'b0);
         end else begin
            do_read(a, 1'b0);
         end
      end
      repeat (4) @(posedge i_clk);

      if (dut0.props0.fail_count != 0) begin
         abort_run("A protocol assertion on the DUT failed");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: verilog.f
source/uart_pkg.sv
source/mem_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/nibble_packer.sv
source/read_assembler.sv
source/mem_bridge_ctrl.sv
source/mem_uart.sv
sim/mem_uart_properties.sv
sim/tb_mem_uart.sv

// File: run.sh
#!/bin/sh
# Build and run the memory bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
   --top-module tb_mem_uart -f verilog.f -o tb_mem_uart

output=$(./obj_dir/tb_mem_uart +verilator+error+limit+100 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
   exit 0
fi
exit 1
